// ==== cache_cfg_pkg.sv ====
`default_nettype none

// Geometry shared by all cache RTL
// Index and tag widths depend on N_SETS and are derived per module
package cache_cfg_pkg;

    // ==================================================================
    // Processor word
    // ==================================================================
    localparam int ADDR_W     = 32;             // Byte address
    localparam int DATA_W     = 32;             // Processor word
    localparam int BE_W       = DATA_W / 8;     // One enable per byte

    // ==================================================================
    // Cache line
    // ==================================================================
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = WORDS_PER_LINE * DATA_W;  // 256 bits
    localparam int BYTE_OFF_W     = 2;          // Byte inside a word
    localparam int WORD_OFF_W     = 3;          // Word inside a line

endpackage

`default_nettype wire

// ==== cache_ctrl_pkg.sv ====
`default_nettype none

// Controller encodings
package cache_ctrl_pkg;

    // Blocking miss sequence, write-back first when the victim is dirty
    typedef enum logic [2:0] {
        IDLE,           // Wait for strobe
        LOOKUP,         // Tag compare on way outputs
        WRITE_BACK,     // Dirty victim out to memory
        WB_DONE,        // One idle cycle between bursts
        REFILL,         // Line fetch
        REFILL_DONE     // Merge and write the victim way
    } cache_state_e;

    // Matches the encoding of p_rw_i
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

endpackage

`default_nettype wire

// ==== dcache_way.sv ====
`default_nettype none

// One cache way with synchronous read
module dcache_way #(
    parameter int N_SETS = 16,
    localparam int IDX_W = $clog2(N_SETS),
    localparam int TAG_W = cache_cfg_pkg::ADDR_W - IDX_W
                           - cache_cfg_pkg::WORD_OFF_W - cache_cfg_pkg::BYTE_OFF_W
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire  [IDX_W-1:0]                   set_index_i,
    input  wire  [TAG_W-1:0]                   req_tag_i,
    input  wire                                we_i,
    input  wire  [cache_cfg_pkg::LINE_W-1:0]   wr_line_i,
    input  wire                                wr_dirty_i,
    output logic                               hit_o,
    output logic [TAG_W-1:0]                   tag_o,
    output logic [cache_cfg_pkg::LINE_W-1:0]   line_o,
    output logic                               dirty_o
);

    // ==================================================================
    // Storage
    // ==================================================================
    logic [TAG_W-1:0]                 tag_mem  [N_SETS];
    logic [cache_cfg_pkg::LINE_W-1:0] line_mem [N_SETS];   // RAM candidate
    logic [N_SETS-1:0]                valid_bits;
    logic [N_SETS-1:0]                dirty_bits;
    logic                             valid_q;           // Valid of last read set

    // Tag and line arrays
    always_ff @(posedge clk)
    begin
        if (we_i)
        begin
            tag_mem[set_index_i]  <= req_tag_i;
            line_mem[set_index_i] <= wr_line_i;
        end
        tag_o  <= tag_mem[set_index_i];     // Read before write
        line_o <= line_mem[set_index_i];
    end

    // Status bits, cleared on reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_bits <= '0;
            dirty_bits <= '0;
            valid_q    <= 1'b0;
            dirty_o    <= 1'b0;
        end
        else
        begin
            if (we_i)
            begin
                valid_bits[set_index_i] <= 1'b1;
                dirty_bits[set_index_i] <= wr_dirty_i;
            end
            valid_q <= valid_bits[set_index_i];
            dirty_o <= dirty_bits[set_index_i];
        end
    end

    // Compare against the latched request tag
    assign hit_o = valid_q && (tag_o == req_tag_i);

endmodule

`default_nettype wire

// ==== dcache_hit_select.sv ====
`default_nettype none

// Reduces per-way results to one hit line and one victim
module dcache_hit_select #(
    parameter int N_WAYS = 4,
    parameter int N_SETS = 16,
    localparam int WAY_W = $clog2(N_WAYS),
    localparam int TAG_W = cache_cfg_pkg::ADDR_W - $clog2(N_SETS)
                           - cache_cfg_pkg::WORD_OFF_W - cache_cfg_pkg::BYTE_OFF_W
) (
    input  wire  [N_WAYS-1:0]                              way_hit_i,
    input  wire  [N_WAYS-1:0][TAG_W-1:0]                   way_tag_i,
    input  wire  [N_WAYS-1:0][cache_cfg_pkg::LINE_W-1:0]   way_line_i,
    input  wire  [N_WAYS-1:0]                              way_dirty_i,
    input  wire  [WAY_W-1:0]                               victim_way_i,
    output logic                                           hit_o,
    output logic [cache_cfg_pkg::LINE_W-1:0]               hit_line_o,
    output logic [TAG_W-1:0]                               victim_tag_o,
    output logic [cache_cfg_pkg::LINE_W-1:0]               victim_line_o,
    output logic                                           victim_dirty_o
);

    // ==================================================================
    // Hit path
    // ==================================================================
    assign hit_o = |way_hit_i;

    // Descending scan so the lowest hitting way wins
    always_comb
    begin
        hit_line_o = '0;
        for (int w = N_WAYS - 1; w >= 0; w--)
        begin
            if (way_hit_i[w])
                hit_line_o = way_line_i[w];
        end
    end

    // Victim path, FIFO pointer from the controller
    assign victim_tag_o   = way_tag_i[victim_way_i];
    assign victim_line_o  = way_line_i[victim_way_i];
    assign victim_dirty_o = way_dirty_i[victim_way_i];

endmodule

`default_nettype wire

// ==== dcache_controller.sv ====
`default_nettype none

module dcache_controller #(
    parameter int N_WAYS = 4,
    parameter int N_SETS = 16,
    localparam int IDX_W = $clog2(N_SETS),
    localparam int WAY_W = $clog2(N_WAYS),
    localparam int OFF_W = cache_cfg_pkg::WORD_OFF_W + cache_cfg_pkg::BYTE_OFF_W,
    localparam int TAG_W = cache_cfg_pkg::ADDR_W - IDX_W - OFF_W
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                p_strobe_i,
    input  wire                                p_rw_i,
    input  wire  [cache_cfg_pkg::BE_W-1:0]     p_be_i,
    input  wire  [cache_cfg_pkg::ADDR_W-1:0]   p_addr_i,
    input  wire  [cache_cfg_pkg::DATA_W-1:0]   p_wdata_i,
    input  wire  [cache_cfg_pkg::LINE_W-1:0]   m_rdata_i,
    input  wire                                m_ready_i,
    input  wire                                hit_i,
    input  wire  [N_WAYS-1:0]                  way_hit_i,
    input  wire  [cache_cfg_pkg::LINE_W-1:0]   hit_line_i,
    input  wire  [TAG_W-1:0]                   victim_tag_i,
    input  wire  [cache_cfg_pkg::LINE_W-1:0]   victim_line_i,
    input  wire                                victim_dirty_i,
    output logic [IDX_W-1:0]                   set_index_o,
    output logic [TAG_W-1:0]                   req_tag_o,
    output logic [cache_cfg_pkg::LINE_W-1:0]   wr_line_o,
    output logic                               wr_dirty_o,
    output logic [N_WAYS-1:0]                  way_we_o,
    output logic [WAY_W-1:0]                   victim_way_o,
    output logic [cache_cfg_pkg::DATA_W-1:0]   p_rdata_o,
    output logic                               p_ready_o,
    output logic [cache_cfg_pkg::ADDR_W-1:0]   m_addr_o,
    output logic [cache_cfg_pkg::LINE_W-1:0]   m_wdata_o,
    output logic                               m_strobe_o,
    output logic                               m_rw_o
);

    cache_ctrl_pkg::cache_state_e state, state_nxt;

    // Request latch
    cache_ctrl_pkg::req_op_e            req_op;
    logic [cache_cfg_pkg::BE_W-1:0]     req_be;
    logic [cache_cfg_pkg::ADDR_W-1:0]   req_addr;
    logic [cache_cfg_pkg::DATA_W-1:0]   req_wdata;

    logic [IDX_W-1:0]                   req_index;
    logic [cache_cfg_pkg::WORD_OFF_W-1:0] req_word;
    logic                               req_wr;
    logic [cache_cfg_pkg::LINE_W-1:0]   refill_line;
    logic [WAY_W-1:0]                   fifo_cnt [N_SETS];  // Next victim per set

    // Replace the enabled bytes of one word inside a line
    function automatic logic [cache_cfg_pkg::LINE_W-1:0] merge_line(
        input logic [cache_cfg_pkg::LINE_W-1:0]     line,
        input logic [cache_cfg_pkg::WORD_OFF_W-1:0] word,
        input logic [cache_cfg_pkg::BE_W-1:0]       be,
        input logic [cache_cfg_pkg::DATA_W-1:0]     wdata
    );
        logic [cache_cfg_pkg::LINE_W-1:0] res;
        res = line;
        for (int b = 0; b < cache_cfg_pkg::BE_W; b++)
        begin
            if (be[b])
                res[word * cache_cfg_pkg::DATA_W + b * 8 +: 8] = wdata[b * 8 +: 8];
        end
        return res;
    endfunction

    // ==================================================================
    // Request latch and field split
    // ==================================================================
    always_ff @(posedge clk)
    begin
        if (state == cache_ctrl_pkg::IDLE && p_strobe_i)
        begin
            req_op    <= cache_ctrl_pkg::req_op_e'(p_rw_i);
            req_be    <= p_be_i;
            req_addr  <= p_addr_i;
            req_wdata <= p_wdata_i;
        end
    end

    assign req_wr    = (req_op == cache_ctrl_pkg::OP_WRITE);
    assign req_word  = req_addr[cache_cfg_pkg::BYTE_OFF_W +: cache_cfg_pkg::WORD_OFF_W];
    assign req_index = req_addr[OFF_W +: IDX_W];
    assign req_tag_o = req_addr[cache_cfg_pkg::ADDR_W-1 -: TAG_W];

    // Ways read one cycle early so LOOKUP sees the new set
    assign set_index_o  = (state == cache_ctrl_pkg::IDLE && p_strobe_i) ?
                          p_addr_i[OFF_W +: IDX_W] : req_index;
    assign victim_way_o = fifo_cnt[req_index];

    // ==================================================================
    // FSM
    // ==================================================================
    always_ff @(posedge clk)
    begin
        if (rst)
            state <= cache_ctrl_pkg::IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;     // Hold by default
        case (state)
            cache_ctrl_pkg::IDLE:
                if (p_strobe_i)
                    state_nxt = cache_ctrl_pkg::LOOKUP;
            cache_ctrl_pkg::LOOKUP:
                if (hit_i)
                    state_nxt = cache_ctrl_pkg::IDLE;
                else if (victim_dirty_i)
                    state_nxt = cache_ctrl_pkg::WRITE_BACK;
                else
                    state_nxt = cache_ctrl_pkg::REFILL;
            cache_ctrl_pkg::WRITE_BACK:
                if (m_ready_i)
                    state_nxt = cache_ctrl_pkg::WB_DONE;
            cache_ctrl_pkg::WB_DONE:
                state_nxt = cache_ctrl_pkg::REFILL;
            cache_ctrl_pkg::REFILL:
                if (m_ready_i)
                    state_nxt = cache_ctrl_pkg::REFILL_DONE;
            cache_ctrl_pkg::REFILL_DONE:
                state_nxt = cache_ctrl_pkg::IDLE;
            default:
                state_nxt = cache_ctrl_pkg::IDLE;
        endcase
    end

    // FIFO victim pointers, one step per refill
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < N_SETS; s++)
                fifo_cnt[s] <= '0;
        end
        else if (state == cache_ctrl_pkg::REFILL_DONE)
            fifo_cnt[req_index] <= fifo_cnt[req_index] + 1'b1;
    end

    // ==================================================================
    // Way write data
    // ==================================================================
    always_ff @(posedge clk)
    begin
        if (state == cache_ctrl_pkg::REFILL && m_ready_i)
            refill_line <= m_rdata_i;                   // Memory line capture
        if (state == cache_ctrl_pkg::LOOKUP && hit_i)
        begin
            wr_line_o  <= merge_line(hit_line_i, req_word, req_be, req_wdata);
            wr_dirty_o <= 1'b1;                         // Only written on a write hit
        end
        else if (state == cache_ctrl_pkg::REFILL_DONE)
        begin
            wr_line_o  <= req_wr ? merge_line(refill_line, req_word, req_be, req_wdata)
                                 : refill_line;
            wr_dirty_o <= req_wr;                       // Write-allocate marks dirty
        end
    end

    // ==================================================================
    // Processor and memory outputs
    // ==================================================================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            p_ready_o  <= 1'b0;
            p_rdata_o  <= '0;
            way_we_o   <= '0;
            m_strobe_o <= 1'b0;
            m_rw_o     <= 1'b0;
            m_addr_o   <= '0;
            m_wdata_o  <= '0;
        end
        else
        begin
            p_ready_o <= 1'b0;      // Pulses
            p_rdata_o <= '0;
            way_we_o  <= '0;
            case (state)
                cache_ctrl_pkg::LOOKUP:
                    if (hit_i)
                    begin
                        p_ready_o <= 1'b1;
                        if (req_wr)
                            way_we_o <= way_hit_i;
                        else
                            p_rdata_o <= hit_line_i[req_word * cache_cfg_pkg::DATA_W +:
                                                    cache_cfg_pkg::DATA_W];
                    end
                    else
                    begin
                        m_strobe_o <= 1'b1;
                        m_rw_o     <= victim_dirty_i;
                        m_addr_o   <= victim_dirty_i ? {victim_tag_i, req_index, OFF_W'(0)}
                                                     : {req_addr[cache_cfg_pkg::ADDR_W-1:OFF_W],
                                                        OFF_W'(0)};
                        m_wdata_o  <= victim_dirty_i ? victim_line_i : '0;
                    end
                cache_ctrl_pkg::WRITE_BACK, cache_ctrl_pkg::REFILL:
                    if (m_ready_i)
                    begin
                        m_strobe_o <= 1'b0;     // Drops the cycle after ready
                        m_rw_o     <= 1'b0;
                        m_addr_o   <= '0;
                        m_wdata_o  <= '0;
                    end
                cache_ctrl_pkg::WB_DONE:
                begin
                    m_strobe_o <= 1'b1;         // Refill of the request line
                    m_addr_o   <= {req_addr[cache_cfg_pkg::ADDR_W-1:OFF_W], OFF_W'(0)};
                end
                cache_ctrl_pkg::REFILL_DONE:
                begin
                    p_ready_o              <= 1'b1;
                    way_we_o[victim_way_o] <= 1'b1;
                    if (!req_wr)
                        p_rdata_o <= refill_line[req_word * cache_cfg_pkg::DATA_W +:
                                                 cache_cfg_pkg::DATA_W];
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
`default_nettype none

// 4-way set-associative write-back L1 data cache
module dcache_top #(
    parameter int N_WAYS = 4,
    parameter int N_SETS = 16,
    localparam int IDX_W = $clog2(N_SETS),
    localparam int WAY_W = $clog2(N_WAYS),
    localparam int TAG_W = cache_cfg_pkg::ADDR_W - IDX_W
                           - cache_cfg_pkg::WORD_OFF_W - cache_cfg_pkg::BYTE_OFF_W
) (
    input  wire                                clk,
    input  wire                                rst,
    // Processor side
    input  wire                                p_strobe_i,
    input  wire                                p_rw_i,       // 1 = write
    input  wire  [cache_cfg_pkg::BE_W-1:0]     p_be_i,
    input  wire  [cache_cfg_pkg::ADDR_W-1:0]   p_addr_i,
    input  wire  [cache_cfg_pkg::DATA_W-1:0]   p_wdata_i,
    output logic [cache_cfg_pkg::DATA_W-1:0]   p_rdata_o,
    output logic                               p_ready_o,
    // Memory side
    input  wire  [cache_cfg_pkg::LINE_W-1:0]   m_rdata_i,
    input  wire                                m_ready_i,
    output logic [cache_cfg_pkg::ADDR_W-1:0]   m_addr_o,
    output logic [cache_cfg_pkg::LINE_W-1:0]   m_wdata_o,
    output logic                               m_strobe_o,
    output logic                               m_rw_o        // 1 = write-back
);

    // ==================================================================
    // Controller to ways, broadcast
    // ==================================================================
    logic [IDX_W-1:0]                 set_index;
    logic [TAG_W-1:0]                 req_tag;
    logic [cache_cfg_pkg::LINE_W-1:0] wr_line;
    logic                             wr_dirty;
    logic [N_WAYS-1:0]                way_we;
    logic [WAY_W-1:0]                 victim_way;

    // Per-way read side
    logic [N_WAYS-1:0]                              way_hit;
    logic [N_WAYS-1:0]                              way_dirty;
    logic [N_WAYS-1:0][TAG_W-1:0]                   way_tag;
    logic [N_WAYS-1:0][cache_cfg_pkg::LINE_W-1:0]   way_line;

    // Hit selector results
    logic                             hit;
    logic [cache_cfg_pkg::LINE_W-1:0] hit_line;
    logic [TAG_W-1:0]                 victim_tag;
    logic [cache_cfg_pkg::LINE_W-1:0] victim_line;
    logic                             victim_dirty;

    dcache_controller #(
        .N_WAYS (N_WAYS),
        .N_SETS (N_SETS)
    ) i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .p_strobe_i     (p_strobe_i),
        .p_rw_i         (p_rw_i),
        .p_be_i         (p_be_i),
        .p_addr_i       (p_addr_i),
        .p_wdata_i      (p_wdata_i),
        .m_rdata_i      (m_rdata_i),
        .m_ready_i      (m_ready_i),
        .hit_i          (hit),
        .way_hit_i      (way_hit),      // Picks the way to update on a write hit
        .hit_line_i     (hit_line),
        .victim_tag_i   (victim_tag),
        .victim_line_i  (victim_line),
        .victim_dirty_i (victim_dirty),
        .set_index_o    (set_index),
        .req_tag_o      (req_tag),
        .wr_line_o      (wr_line),
        .wr_dirty_o     (wr_dirty),
        .way_we_o       (way_we),
        .victim_way_o   (victim_way),
        .p_rdata_o      (p_rdata_o),
        .p_ready_o      (p_ready_o),
        .m_addr_o       (m_addr_o),
        .m_wdata_o      (m_wdata_o),
        .m_strobe_o     (m_strobe_o),
        .m_rw_o         (m_rw_o)
    );

    // Identical ways, one write enable each
    for (genvar w = 0; w < N_WAYS; w++)
    begin : g_way
        dcache_way #(
            .N_SETS (N_SETS)
        ) i_way (
            .clk         (clk),
            .rst         (rst),
            .set_index_i (set_index),
            .req_tag_i   (req_tag),
            .we_i        (way_we[w]),
            .wr_line_i   (wr_line),
            .wr_dirty_i  (wr_dirty),
            .hit_o       (way_hit[w]),
            .tag_o       (way_tag[w]),
            .line_o      (way_line[w]),
            .dirty_o     (way_dirty[w])
        );
    end

    dcache_hit_select #(
        .N_WAYS (N_WAYS),
        .N_SETS (N_SETS)
    ) i_hit_sel (
        .way_hit_i      (way_hit),
        .way_tag_i      (way_tag),
        .way_line_i     (way_line),
        .way_dirty_i    (way_dirty),
        .victim_way_i   (victim_way),
        .hit_o          (hit),
        .hit_line_o     (hit_line),
        .victim_tag_o   (victim_tag),
        .victim_line_o  (victim_line),
        .victim_dirty_o (victim_dirty)
    );

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`default_nettype none

// Line-wide main memory behind the cache, random response delay
module tb_mem_model (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                m_strobe_i,
    input  wire                                m_rw_i,       // 1 = write-back
    input  wire  [cache_cfg_pkg::ADDR_W-1:0]   m_addr_i,
    input  wire  [cache_cfg_pkg::LINE_W-1:0]   m_wdata_i,
    output logic                               m_ready_o,
    output logic [cache_cfg_pkg::LINE_W-1:0]   m_rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [cache_cfg_pkg::LINE_W-1:0] lines [logic [cache_cfg_pkg::ADDR_W-1:0]];  // Written back
    integer seed = 32'h20b9;
    int     delay;                                       // Cycles until ready

    // Stored line if written back, address pattern otherwise
    function automatic logic [cache_cfg_pkg::LINE_W-1:0] fetch_line(
        input logic [cache_cfg_pkg::ADDR_W-1:0] base
    );
        logic [cache_cfg_pkg::LINE_W-1:0] res;
        if (lines.exists(base))
            res = lines[base];
        else
        begin
            for (int w = 0; w < cache_cfg_pkg::WORDS_PER_LINE; w++)
                res[w * 32 +: 32] = (base + 4 * w) ^ 32'hC0DE0000;
        end
        return res;
    endfunction

    initial
    begin
        m_ready_o = 1'b0;
        m_rdata_o = '0;
        forever
        begin
            @(posedge clk);
            if (!rst && m_strobe_i)
            begin
                delay = 1 + ($unsigned($random(seed)) % 8);
                repeat (delay - 1) @(posedge clk);
                if (m_rw_i)
                    lines[m_addr_i] = m_wdata_i;         // Record write-back
                else
                    m_rdata_o <= fetch_line(m_addr_i);
                m_ready_o <= 1'b1;                       // One-cycle pulse
                @(posedge clk);
                m_ready_o <= 1'b0;
                m_rdata_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dcache_sva.sv ====
`default_nettype none

// Port protocol properties, bound into dcache_top
module dcache_sva (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                p_ready_i,
    input  wire  [cache_cfg_pkg::DATA_W-1:0]   p_rdata_i,
    input  wire                                m_strobe_i,
    input  wire                                m_ready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;      // Read by the testbench top

    // Ready is a single-cycle pulse
    ready_pulse: assert property (@(posedge clk) disable iff (rst)
        p_ready_i |=> !p_ready_i)
    else
    begin
        fail_cnt++;
        $error("p_ready_o stayed high for two cycles");
    end

    // Memory strobe is a level held until the memory answers
    strobe_held: assert property (@(posedge clk) disable iff (rst)
        (m_strobe_i && !m_ready_i) |=> m_strobe_i)
    else
    begin
        fail_cnt++;
        $error("m_strobe_o dropped before m_ready_i");
    end

    // Read data only alongside ready
    rdata_quiet: assert property (@(posedge clk) disable iff (rst)
        !p_ready_i |-> (p_rdata_i == '0))
    else
    begin
        fail_cnt++;
        $error("p_rdata_o nonzero while p_ready_o is low");
    end

endmodule

`default_nettype wire

// ==== tb_dcache.sv ====
`default_nettype none

// Testbench top for the set-associative data cache
module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_WAYS     = 4;
    localparam int N_SETS     = 16;
    localparam int RST_CYCLES = 16;

    logic                               clk;
    logic                               rst;
    logic                               p_strobe_i;
    logic                               p_rw_i;
    logic [cache_cfg_pkg::BE_W-1:0]     p_be_i;
    logic [cache_cfg_pkg::ADDR_W-1:0]   p_addr_i;
    logic [cache_cfg_pkg::DATA_W-1:0]   p_wdata_i;
    logic [cache_cfg_pkg::DATA_W-1:0]   p_rdata_o;
    logic                               p_ready_o;
    logic [cache_cfg_pkg::LINE_W-1:0]   m_rdata_i;
    logic                               m_ready_i;
    logic [cache_cfg_pkg::ADDR_W-1:0]   m_addr_o;
    logic [cache_cfg_pkg::LINE_W-1:0]   m_wdata_o;
    logic                               m_strobe_o;
    logic                               m_rw_o;

    // ==================================================================
    // Request table with one entry per stimulus line
    // ==================================================================
    string       t_name   [$];
    logic        t_op     [$];      // 1 = write
    logic [31:0] t_addr   [$];
    logic [3:0]  t_be     [$];
    logic [31:0] t_wdata  [$];
    logic [31:0] t_rdata  [$];      // Expected read word or zero for writes
    int          t_refill [$];
    int          t_wb     [$];

    int checks;
    int errors;
    int cycles;
    int limit;                      // Timeout in cycles set after loading

    dcache_top #(
        .N_WAYS (N_WAYS),
        .N_SETS (N_SETS)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .p_strobe_i (p_strobe_i),
        .p_rw_i     (p_rw_i),
        .p_be_i     (p_be_i),
        .p_addr_i   (p_addr_i),
        .p_wdata_i  (p_wdata_i),
        .p_rdata_o  (p_rdata_o),
        .p_ready_o  (p_ready_o),
        .m_rdata_i  (m_rdata_i),
        .m_ready_i  (m_ready_i),
        .m_addr_o   (m_addr_o),
        .m_wdata_o  (m_wdata_o),
        .m_strobe_o (m_strobe_o),
        .m_rw_o     (m_rw_o)
    );

    tb_mem_model i_mem (
        .clk        (clk),
        .rst        (rst),
        .m_strobe_i (m_strobe_o),
        .m_rw_i     (m_rw_o),
        .m_addr_i   (m_addr_o),
        .m_wdata_i  (m_wdata_o),
        .m_ready_o  (m_ready_i),
        .m_rdata_o  (m_rdata_i)
    );

    bind dcache_top dcache_sva i_sva (
        .clk        (clk),
        .rst        (rst),
        .p_ready_i  (p_ready_o),
        .p_rdata_i  (p_rdata_o),
        .m_strobe_i (m_strobe_o),
        .m_ready_i  (m_ready_i)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 100 MHz
    end

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", test, what, exp, act);
        end
    endtask

    task automatic check_quiet_outputs();
        check_value("reset_quiet", "p_ready_o", 32'd0, {31'd0, p_ready_o});
        check_value("reset_quiet", "m_strobe_o", 32'd0, {31'd0, m_strobe_o});
        check_value("reset_quiet", "m_rw_o", 32'd0, {31'd0, m_rw_o});
        check_value("reset_quiet", "p_rdata_o", 32'd0, p_rdata_o);
    endtask

    // Stimulus columns are name op addr be wdata rdata refill wb
    task automatic load_stimulus();
        int    fd;
        int    code;
        int    n;
        string line;
        string name;
        int    op;
        int    refill;
        int    wb;
        logic [31:0] addr;
        logic [31:0] be;
        logic [31:0] wdata;
        logic [31:0] rdata;
        fd = $fopen("dcache_stimulus.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("Could not open the stimulus file dcache_stimulus.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#")   // Skip blanks and comments
                begin
                    n = $sscanf(line, "%s %d %h %h %h %h %d %d",
                                name, op, addr, be, wdata, rdata, refill, wb);
                    if (n == 8)
                    begin
                        t_name.push_back(name);
                        t_op.push_back(op[0]);
                        t_addr.push_back(addr);
                        t_be.push_back(be[3:0]);
                        t_wdata.push_back(wdata);
                        t_rdata.push_back(rdata);
                        t_refill.push_back(refill);
                        t_wb.push_back(wb);
                    end
                    else
                    begin
                        errors++;
                        $display("Malformed line in the stimulus file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        if (t_name.size() == 0)
        begin
            errors++;
            $display("No requests were loaded from the stimulus file");
        end
    endtask

    // One request and the wait for ready while counting memory bursts
    task automatic run_request(input int idx);
        int   lat;
        int   n_rd;
        int   n_wb;
        int   n_late_wb;
        logic prev_strobe;
        logic got;
        lat         = 0;
        n_rd        = 0;
        n_wb        = 0;
        n_late_wb   = 0;
        prev_strobe = m_strobe_o;
        got         = 1'b0;
        @(posedge clk);
        p_strobe_i <= 1'b1;
        p_rw_i     <= t_op[idx];
        p_be_i     <= t_be[idx];
        p_addr_i   <= t_addr[idx];
        p_wdata_i  <= t_wdata[idx];
        while (!got)
        begin
            @(posedge clk);
            p_strobe_i <= 1'b0;         // One-cycle strobe
            lat++;
            @(negedge clk);
            if (m_strobe_o && !prev_strobe)
            begin
                if (m_rw_o)
                begin
                    n_wb++;
                    if (n_rd > 0)
                        n_late_wb++;    // Write-back must precede the refill
                end
                else
                    n_rd++;
            end
            prev_strobe = m_strobe_o;
            got         = p_ready_o;
        end
        check_value(t_name[idx], "p_rdata_o", t_rdata[idx], p_rdata_o);
        check_value(t_name[idx], "refills", t_refill[idx], n_rd);
        check_value(t_name[idx], "write_backs", t_wb[idx], n_wb);
        check_value(t_name[idx], "write_backs_after_refill", 32'd0, n_late_wb);
        if (t_refill[idx] == 0 && t_wb[idx] == 0)
            check_value(t_name[idx], "hit_latency", 32'd2, lat);
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial
    begin
        checks     = 0;
        errors     = 0;
        limit      = 0;
        rst        = 1'b1;
        p_strobe_i = 1'b0;
        p_rw_i     = 1'b0;
        p_be_i     = '0;
        p_addr_i   = '0;
        p_wdata_i  = '0;
        load_stimulus();
        limit = t_name.size() * 30 + RST_CYCLES + 100;
        repeat (RST_CYCLES - 1)
        begin
            @(negedge clk);
            check_quiet_outputs();
        end
        @(posedge clk);
        rst <= 1'b0;                // 16th reset edge samples it still high
        repeat (2)
        begin
            @(negedge clk);
            check_quiet_outputs();  // Right after release
        end
        for (int i = 0; i < t_name.size(); i++)
            run_request(i);
        repeat (4) @(posedge clk);  // Let the last properties settle
        errors += i_dut.i_sva.fail_cnt;
        $display("Checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, i_dut.i_sva.fail_cnt);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Cycle limit against a hung handshake
    initial
    begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the cache did not finish within %0d cycles", limit);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache_stimulus.txt ====
# name op(1=write) addr be wdata exp_rdata exp_refill exp_writeback
# all numbers hex except op and the two flags
rd_miss        0 00000104 0 00000000 c0de0104 1 0
rd_hit         0 00000118 0 00000000 c0de0118 0 0
wr_hit_part    1 00000104 c deadbeef 00000000 0 0
rd_wr_hit      0 00000104 0 00000000 dead0104 0 0
wr_miss_part   1 000010a8 5 aabbccdd 00000000 1 0
rd_wr_miss     0 000010a8 0 00000000 c0bb10dd 0 0
wr_hit_part2   1 000010a8 a 11223344 00000000 0 0
rd_wr_hit2     0 000010a8 0 00000000 11bb33dd 0 0
fifo_fill0     0 00000060 0 00000000 c0de0060 1 0
fifo_fill1     0 00000264 0 00000000 c0de0264 1 0
fifo_fill2     0 00000468 0 00000000 c0de0468 1 0
fifo_fill3     0 0000066c 0 00000000 c0de066c 1 0
fifo_fill4     0 00000870 0 00000000 c0de0870 1 0
fifo_hit1      0 0000027c 0 00000000 c0de027c 0 0
fifo_hit2      0 00000460 0 00000000 c0de0460 0 0
fifo_hit3      0 00000678 0 00000000 c0de0678 0 0
fifo_hit4      0 00000874 0 00000000 c0de0874 0 0
fifo_oldest    0 00000060 0 00000000 c0de0060 1 0
wb_fill1       0 00000300 0 00000000 c0de0300 1 0
wb_fill2       0 00000504 0 00000000 c0de0504 1 0
wb_fill3       0 00000708 0 00000000 c0de0708 1 0
wb_evict       0 0000090c 0 00000000 c0de090c 1 1
wb_reread      0 00000104 0 00000000 dead0104 1 0
wb_other_word  0 00000118 0 00000000 c0de0118 0 0

// ==== files.f ====
cache_cfg_pkg.sv
cache_ctrl_pkg.sv
dcache_way.sv
dcache_hit_select.sv
dcache_controller.sv
dcache_top.sv
tb_mem_model.sv
dcache_sva.sv
tb_dcache.sv
